//--- rtl/jtshouse_pkg.sv
// Shared definitions for the arcade CPU bus model
//  - address map, bus sizes and key chip constants
//  - address union with ROM and I/O views
//  - target enumeration and the stage structs

package jtshouse_pkg;

    localparam int ADDR_W     = 22;
    localparam int DATA_W     = 8;
    localparam int RAM_AW     = 11;     // 2 KB, mirrored inside its region
    localparam int VRAM_AW    = 10;     // 16-bit words
    localparam int BANK_W     = 3;
    localparam int ROM_OFFS_W = 17;
    localparam int REG_W      = 6;
    localparam int OFFS_W     = 15;
    localparam int KEY_AW     = 3;

    // I/O region codes, valid with bit 21 clear
    localparam logic [REG_W-1:0] REG_RAM  = 6'd0;
    localparam logic [REG_W-1:0] REG_VRAM = 6'd1;
    localparam logic [REG_W-1:0] REG_KEY  = 6'd2;

    localparam logic [DATA_W-1:0] KEY_ID   = 8'hB6;
    localparam logic [DATA_W-1:0] ERR_DATA = 8'hFF;

    // ROM view of the byte address
    typedef struct packed {
        logic [BANK_W-1:0]     bank;
        logic [1:0]            unused;
        logic [ROM_OFFS_W-1:0] offset;
    } rom_view_t;

    // I/O view of the byte address
    typedef struct packed {
        logic              is_rom;
        logic [REG_W-1:0]  region;
        logic [OFFS_W-1:0] offset;
    } io_view_t;

    // Bit 21 tells which view applies
    typedef union packed {
        rom_view_t rom;
        io_view_t  io;
    } bus_addr_u;

    typedef enum logic [2:0] {
        TGT_ROM,
        TGT_RAM,
        TGT_VRAM,
        TGT_KEY,
        TGT_NONE
    } target_e;

    typedef struct packed {
        bus_addr_u         addr;
        logic              wr;
        logic [DATA_W-1:0] wdata;
        logic              valid;
    } bus_req_t;

    typedef struct packed {
        target_e           target;
        logic [ADDR_W-1:0] rom_addr;
        logic [OFFS_W-1:0] offset;
        logic              wr;
        logic [DATA_W-1:0] wdata;
        logic              valid;
    } dec_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
        logic              valid;
    } bus_rsp_t;

endpackage

//--- rtl/jtshouse_apb_port.sv
// APB slave port of the CPU bus
//  - captures the setup cycle as a one-cycle request
//  - registers the bus response onto prdata, pready and pslverr

`timescale 1ns/1ps

module jtshouse_apb_port(
    input                                   clk,
    input                                   rst_n,

    // APB slave
    input                                   psel,
    input                                   penable,
    input                                   pwrite,
    input        [jtshouse_pkg::ADDR_W-1:0] paddr,
    input        [jtshouse_pkg::DATA_W-1:0] pwdata,
    output logic [jtshouse_pkg::DATA_W-1:0] prdata,
    output logic                            pready,
    output logic                            pslverr,

    // Internal bus
    output jtshouse_pkg::bus_req_t          req,
    input  jtshouse_pkg::bus_rsp_t          rsp
);

    import jtshouse_pkg::*;

    logic started;
    logic setup;

    // A setup held longer than one cycle is taken only once
    assign setup = psel && !penable && !started;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            started   <= 1'b0;
            req.valid <= 1'b0;
            pready    <= 1'b0;
            pslverr   <= 1'b0;
        end else begin
            req.valid <= setup;
            if (setup) begin
                started <= 1'b1;
            end else if (pready) begin
                started <= 1'b0;
            end
            // rsp.valid is a single pulse, so is pready
            pready  <= rsp.valid;
            pslverr <= rsp.valid && rsp.err;
        end
    end

    // Transfer payload
    always_ff @(posedge clk) begin
        if (setup) begin
            req.addr  <= paddr;
            req.wr    <= pwrite;
            req.wdata <= pwdata;
        end
    end

    // Read data for the closing access cycle
    always_ff @(posedge clk) begin
        if (rsp.valid) begin
            prdata <= rsp.rdata;
        end
    end

endmodule

//--- rtl/jtshouse_bus_decode.sv
// Address decode stage
//  - picks ROM, RAM, VRAM, key chip or nothing from the byte address
//  - builds the ROM address, bit 16 inverted in the top bank
//  - registers the decoded request

`timescale 1ns/1ps

module jtshouse_bus_decode(
    input                          clk,
    input                          rst_n,

    input  jtshouse_pkg::bus_req_t req,
    output jtshouse_pkg::dec_req_t dec
);

    import jtshouse_pkg::*;

    target_e               tgt_next;
    logic [ADDR_W-1:0]     rom_next;
    logic [BANK_W-1:0]     bank;
    logic [ROM_OFFS_W-1:0] rom_offs;

    assign bank     = req.addr.rom.bank;
    assign rom_offs = req.addr.rom.offset;

    always_comb begin
        if (req.addr.io.is_rom) begin
            tgt_next = TGT_ROM;
        end else begin
            case (req.addr.io.region)
                REG_RAM:  tgt_next = TGT_RAM;
                REG_VRAM: tgt_next = TGT_VRAM;
                REG_KEY:  tgt_next = TGT_KEY;
                default:  tgt_next = TGT_NONE;
            endcase
        end
    end

    // The last bank has its bit 16 flipped on the board
    always_comb begin
        rom_next = {bank, 2'b00, rom_offs};
        if (&bank) begin
            rom_next[ROM_OFFS_W-1] = ~rom_offs[ROM_OFFS_W-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= req.valid;
        end
        if (req.valid) begin
            dec.target   <= tgt_next;
            dec.rom_addr <= rom_next;
            dec.offset   <= req.addr.io.offset;
            dec.wr       <= req.wr;
            dec.wdata    <= req.wdata;
        end
    end

endmodule

//--- rtl/jtshouse_key.sv
// Protection key chip
//  - ID register at offset 0
//  - two operand registers and their 16-bit product

`timescale 1ns/1ps

module jtshouse_key(
    input                                   clk,
    input                                   rst_n,

    input                                   cs,
    input                                   wr,
    input        [jtshouse_pkg::KEY_AW-1:0] offset,
    input        [jtshouse_pkg::DATA_W-1:0] din,
    output logic [jtshouse_pkg::DATA_W-1:0] dout
);

    import jtshouse_pkg::*;

    logic [DATA_W-1:0]   op_a;
    logic [DATA_W-1:0]   op_b;
    logic [2*DATA_W-1:0] product;

    assign product = op_a * op_b;

    // Only the operand registers take writes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_a <= '0;
            op_b <= '0;
        end else if (cs && wr) begin
            case (offset)
                3'd1:    op_a <= din;
                3'd2:    op_b <= din;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (offset)
            3'd0:    dout = KEY_ID;
            3'd1:    dout = op_a;
            3'd2:    dout = op_b;
            3'd3:    dout = product[DATA_W-1:0];
            3'd4:    dout = product[2*DATA_W-1:DATA_W];
            default: dout = '0;
        endcase
    end

endmodule

//--- rtl/jtshouse_bus_access.sv
// Access stage of the CPU bus
//  - work RAM, mirrored every 2 KB
//  - byte-laned video RAM
//  - ROM request port with a wait state on rom_ok
//  - key chip strobes and the bus response

`timescale 1ns/1ps

module jtshouse_bus_access(
    input                                   clk,
    input                                   rst_n,

    input  jtshouse_pkg::dec_req_t          dec,
    output jtshouse_pkg::bus_rsp_t          rsp,

    // ROM port
    output logic                            rom_cs,
    output logic [jtshouse_pkg::ADDR_W-1:0] rom_addr,
    input        [jtshouse_pkg::DATA_W-1:0] rom_data,
    input                                   rom_ok,

    // Key chip
    output logic                            key_cs,
    output logic                            key_wr,
    output logic [jtshouse_pkg::KEY_AW-1:0] key_offset,
    output logic [jtshouse_pkg::DATA_W-1:0] key_din,
    input        [jtshouse_pkg::DATA_W-1:0] key_dout
);

    import jtshouse_pkg::*;

    logic [DATA_W-1:0]            ram_mem  [2**RAM_AW];
    logic [1:0][DATA_W-1:0]       vram_mem [2**VRAM_AW];

    logic [RAM_AW-1:0]  ram_addr;
    logic [VRAM_AW-1:0] vram_word;
    logic               vram_lane;
    logic [DATA_W-1:0]  ram_rd;
    logic [DATA_W-1:0]  vram_rd;
    logic               rom_rd;
    logic               rom_done;
    logic [DATA_W-1:0]  rom_q;

    assign ram_addr  = dec.offset[RAM_AW-1:0];
    assign vram_word = dec.offset[VRAM_AW:1];
    assign vram_lane = dec.offset[0];
    assign ram_rd    = ram_mem[ram_addr];
    assign vram_rd   = vram_mem[vram_word][vram_lane];
    assign rom_rd    = dec.valid && dec.target == TGT_ROM && !dec.wr;

    // Key chip sees the decoded request directly
    assign key_cs     = dec.valid && dec.target == TGT_KEY;
    assign key_wr     = dec.wr;
    assign key_offset = dec.offset[KEY_AW-1:0];
    assign key_din    = dec.wdata;

    always_ff @(posedge clk) begin
        if (dec.valid && dec.wr && dec.target == TGT_RAM) begin
            ram_mem[ram_addr] <= dec.wdata;
        end
    end

    // Lane 0 is the low byte
    always_ff @(posedge clk) begin
        if (dec.valid && dec.wr && dec.target == TGT_VRAM) begin
            vram_mem[vram_word][vram_lane] <= dec.wdata;
        end
    end

    // ROM wait state, held until rom_ok
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rom_cs   <= 1'b0;
            rom_done <= 1'b0;
        end else begin
            rom_done <= 1'b0;
            if (rom_cs && rom_ok) begin
                rom_cs   <= 1'b0;
                rom_done <= 1'b1;
            end else if (rom_rd) begin
                rom_cs <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rom_rd) begin
            rom_addr <= dec.rom_addr;
        end
        if (rom_cs && rom_ok) begin
            rom_q <= rom_data;
        end
    end

    // Local targets answer while the decoded request is present,
    // ROM reads one cycle after rom_ok
    always_comb begin
        rsp.valid = rom_done;
        rsp.rdata = rom_q;
        rsp.err   = 1'b0;
        if (dec.valid && !rom_rd) begin
            rsp.valid = 1'b1;
            case (dec.target)
                TGT_RAM:  rsp.rdata = ram_rd;
                TGT_VRAM: rsp.rdata = vram_rd;
                TGT_KEY:  rsp.rdata = key_dout;
                default: begin
                    // ROM writes and unmapped regions
                    rsp.rdata = ERR_DATA;
                    rsp.err   = 1'b1;
                end
            endcase
        end
    end

endmodule

//--- rtl/jtshouse_bus.sv
// Top level of the CPU bus model
//  - APB capture, address decode and access stages
//  - protection key chip beside the access stage

`timescale 1ns/1ps

module jtshouse_bus(
    input                                   clk,
    input                                   rst_n,

    // APB slave, clocked by clk
    input                                   psel,
    input                                   penable,
    input                                   pwrite,
    input        [jtshouse_pkg::ADDR_W-1:0] paddr,
    input        [jtshouse_pkg::DATA_W-1:0] pwdata,
    output logic [jtshouse_pkg::DATA_W-1:0] prdata,
    output logic                            pready,
    output logic                            pslverr,

    // ROM port
    output logic                            rom_cs,
    output logic [jtshouse_pkg::ADDR_W-1:0] rom_addr,
    input        [jtshouse_pkg::DATA_W-1:0] rom_data,
    input                                   rom_ok
);

    import jtshouse_pkg::*;

    bus_req_t          req;
    dec_req_t          dec;
    bus_rsp_t          rsp;
    logic              key_cs;
    logic              key_wr;
    logic [KEY_AW-1:0] key_offset;
    logic [DATA_W-1:0] key_din;
    logic [DATA_W-1:0] key_dout;

    jtshouse_apb_port u_apb(
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .psel       ( psel      ),
        .penable    ( penable   ),
        .pwrite     ( pwrite    ),
        .paddr      ( paddr     ),
        .pwdata     ( pwdata    ),
        .prdata     ( prdata    ),
        .pready     ( pready    ),
        .pslverr    ( pslverr   ),
        .req        ( req       ),
        .rsp        ( rsp       )
    );

    jtshouse_bus_decode u_decode(
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .req        ( req       ),
        .dec        ( dec       )
    );

    jtshouse_bus_access u_access(
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .dec        ( dec       ),
        .rsp        ( rsp       ),
        .rom_cs     ( rom_cs    ),
        .rom_addr   ( rom_addr  ),
        .rom_data   ( rom_data  ),
        .rom_ok     ( rom_ok    ),
        .key_cs     ( key_cs    ),
        .key_wr     ( key_wr    ),
        .key_offset ( key_offset),
        .key_din    ( key_din   ),
        .key_dout   ( key_dout  )
    );

    jtshouse_key u_key(
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .cs         ( key_cs    ),
        .wr         ( key_wr    ),
        .offset     ( key_offset),
        .din        ( key_din   ),
        .dout       ( key_dout  )
    );

endmodule

//--- tests/jtshouse_bus_sva.sv
// Assertions bound to the CPU bus top level
//  - APB pready and pslverr rules
//  - ROM request held until rom_ok
//  - outputs cleared by reset

`timescale 1ns/1ps

module jtshouse_bus_sva(
    input                            clk,
    input                            rst_n,
    input                            psel,
    input                            penable,
    input                            pready,
    input                            pslverr,
    input                            rom_cs,
    input [jtshouse_pkg::ADDR_W-1:0] rom_addr,
    input                            rom_ok
);

    pready_in_access: assert property (
        @(posedge clk) disable iff (!rst_n) pready |-> psel && penable
    ) else $error("pready high outside an APB access phase");

    pslverr_with_pready: assert property (
        @(posedge clk) disable iff (!rst_n) pslverr |-> pready
    ) else $error("pslverr high without pready");

    // Request stays up with a steady address until the ROM answers
    rom_hold: assert property (
        @(posedge clk) disable iff (!rst_n) rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr)
    ) else $error("rom_cs or rom_addr changed before rom_ok");

    reset_clears: assert property (
        @(posedge clk) !rst_n |=> !pready && !pslverr && !rom_cs
    ) else $error("outputs not cleared by reset");

endmodule

//--- tests/jtshouse_bus_tb.sv
// Directed testbench for the CPU bus model
//  - clock, reset and APB master tasks
//  - ROM model answering after an LCG-chosen delay
//  - work RAM, VRAM, key chip, ROM remap and error tests
//  - watchdog bounding the run

`timescale 1ns/1ps

module jtshouse_bus_tb;

    import jtshouse_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int RAM_SIZE     = 2**RAM_AW;
    localparam int RAM_TESTS    = 16;
    localparam int VRAM_TESTS   = 4;
    localparam int KEY_TESTS    = 4;
    localparam int ROM_PER_BANK = 3;
    // Transfers issued by all tests together
    localparam int NUM_XFERS    = RAM_SIZE + 1 + 3*RAM_TESTS + 7*VRAM_TESTS
                                + 3 + 4*KEY_TESTS + 4*ROM_PER_BANK + 6;
    localparam int WATCHDOG_CYCLES = NUM_XFERS*20 + RESET_CYCLES;

    logic              clk;
    logic              rst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              rom_cs;
    logic [ADDR_W-1:0] rom_addr;
    logic [DATA_W-1:0] rom_data;
    logic              rom_ok;

    int                errors = 0;
    int                checks = 0;
    logic [31:0]       lcg_state = 32'd20608;
    logic [ADDR_W-1:0] rom_seen;
    logic [DATA_W-1:0] ram_model [RAM_SIZE];

    jtshouse_bus jtshouse_bus_i(
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .psel     ( psel     ),
        .penable  ( penable  ),
        .pwrite   ( pwrite   ),
        .paddr    ( paddr    ),
        .pwdata   ( pwdata   ),
        .prdata   ( prdata   ),
        .pready   ( pready   ),
        .pslverr  ( pslverr  ),
        .rom_cs   ( rom_cs   ),
        .rom_addr ( rom_addr ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   )
    );

    bind jtshouse_bus jtshouse_bus_sva u_sva(
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .psel     ( psel     ),
        .penable  ( penable  ),
        .pready   ( pready   ),
        .pslverr  ( pslverr  ),
        .rom_cs   ( rom_cs   ),
        .rom_addr ( rom_addr ),
        .rom_ok   ( rom_ok   )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [23:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:8];
    endfunction

    function automatic logic [ADDR_W-1:0] io_addr(input logic [REG_W-1:0]  region,
                                                  input logic [OFFS_W-1:0] offs);
        return {1'b0, region, offs};
    endfunction

    // Expected ROM address with bit 16 flipped in bank 7
    function automatic logic [ADDR_W-1:0] rom_remap(input logic [ADDR_W-1:0] cpu_addr);
        logic [ADDR_W-1:0] mapped;
        mapped        = cpu_addr;
        mapped[18:17] = 2'b00;
        if (cpu_addr[21:19] == 3'd7) begin
            mapped[16] = ~cpu_addr[16];
        end
        return mapped;
    endfunction

    // ROM model returning the low address byte XOR 0x5A
    initial begin
        int delay;
        rom_ok   = 1'b0;
        rom_data = '0;
        rom_seen = '0;
        forever begin
            @(negedge clk);
            if (rom_cs) begin
                delay = 1 + int'(lcg_next() % 24'd6);
                repeat (delay - 1) @(negedge clk);
                rom_seen = rom_addr;
                rom_data = rom_addr[DATA_W-1:0] ^ 8'h5A;
                rom_ok   = 1'b1;
                @(negedge clk);
                rom_ok   = 1'b0;
            end
        end
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED at %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    // One APB transfer with cycles counting access-phase cycles up to pready
    task automatic apb_transfer(input  logic              wr,
                                input  logic [ADDR_W-1:0] addr,
                                input  logic [DATA_W-1:0] wdata,
                                output logic [DATA_W-1:0] rdata,
                                output logic              err,
                                output int                cycles);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        cycles  = 1;
        do begin
            @(negedge clk);
            cycles++;
        end while (!pready);
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_expect(input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] data,
                                input logic              exp_err);
        logic [DATA_W-1:0] rdata;
        logic              err;
        int                cycles;
        apb_transfer(1'b1, addr, data, rdata, err, cycles);
        compare_value("pslverr", 32'(exp_err), 32'(err));
        if (exp_err) begin
            compare_value("prdata", 32'hFF, 32'(rdata));
        end
    endtask

    task automatic read_expect(input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] exp_data,
                               input logic              exp_err);
        logic [DATA_W-1:0] rdata;
        logic              err;
        int                cycles;
        apb_transfer(1'b0, addr, 8'h00, rdata, err, cycles);
        compare_value("prdata", 32'(exp_data), 32'(rdata));
        compare_value("pslverr", 32'(exp_err), 32'(err));
    endtask

    task automatic reset_checks();
        compare_value("pready", 0, 32'(pready));
        compare_value("pslverr", 0, 32'(pslverr));
        compare_value("rom_cs", 0, 32'(rom_cs));
        // Clear the work RAM so later reads have known contents
        for (int i = 0; i < RAM_SIZE; i++) begin
            write_expect(io_addr(REG_RAM, 15'(i)), 8'h00, 1'b0);
            ram_model[i] = 8'h00;
        end
        read_expect(io_addr(REG_RAM, 15'd0), 8'h00, 1'b0);
    endtask

    task automatic ram_mirror_test();
        logic [OFFS_W-1:0] offs [RAM_TESTS];
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] rdata;
        logic              err;
        int                cycles;
        for (int i = 0; i < RAM_TESTS; i++) begin
            offs[i] = 15'(lcg_next());
            data    = 8'(lcg_next());
            write_expect(io_addr(REG_RAM, offs[i]), data, 1'b0);
            ram_model[offs[i][RAM_AW-1:0]] = data;
        end
        for (int i = 0; i < RAM_TESTS; i++) begin
            apb_transfer(1'b0, io_addr(REG_RAM, offs[i]), 8'h00, rdata, err, cycles);
            compare_value("prdata", 32'(ram_model[offs[i][RAM_AW-1:0]]), 32'(rdata));
            compare_value("pslverr", 0, 32'(err));
            compare_value("access cycles", 3, 32'(cycles));
            // Same byte 2 KB higher
            read_expect(io_addr(REG_RAM, offs[i] + 15'h800),
                        ram_model[offs[i][RAM_AW-1:0]], 1'b0);
        end
    endtask

    task automatic vram_lane_test();
        logic [VRAM_AW-1:0] word;
        logic [OFFS_W-1:0]  even;
        logic [DATA_W-1:0]  lo;
        logic [DATA_W-1:0]  hi;
        for (int i = 0; i < VRAM_TESTS; i++) begin
            word = VRAM_AW'(lcg_next());
            even = {4'b0000, word, 1'b0};
            lo   = 8'(lcg_next());
            hi   = 8'(lcg_next());
            write_expect(io_addr(REG_VRAM, even), lo, 1'b0);
            write_expect(io_addr(REG_VRAM, even | 15'd1), hi, 1'b0);
            read_expect(io_addr(REG_VRAM, even), lo, 1'b0);
            read_expect(io_addr(REG_VRAM, even | 15'd1), hi, 1'b0);
            // New low byte, high lane must survive
            write_expect(io_addr(REG_VRAM, even), ~lo, 1'b0);
            read_expect(io_addr(REG_VRAM, even | 15'd1), hi, 1'b0);
            read_expect(io_addr(REG_VRAM, even), ~lo, 1'b0);
        end
    endtask

    task automatic key_chip_test();
        logic [DATA_W-1:0]   a;
        logic [DATA_W-1:0]   b;
        logic [2*DATA_W-1:0] prod;
        read_expect(io_addr(REG_KEY, 15'd0), KEY_ID, 1'b0);
        write_expect(io_addr(REG_KEY, 15'd0), 8'(lcg_next()), 1'b0);
        read_expect(io_addr(REG_KEY, 15'd0), KEY_ID, 1'b0);
        for (int i = 0; i < KEY_TESTS; i++) begin
            a    = 8'(lcg_next());
            b    = 8'(lcg_next());
            prod = 16'(a) * 16'(b);
            write_expect(io_addr(REG_KEY, 15'd1), a, 1'b0);
            write_expect(io_addr(REG_KEY, 15'd2), b, 1'b0);
            read_expect(io_addr(REG_KEY, 15'd3), prod[7:0], 1'b0);
            read_expect(io_addr(REG_KEY, 15'd4), prod[15:8], 1'b0);
        end
    endtask

    // Bit 21 is also the ROM flag, so only banks 4 to 7 reach ROM
    task automatic rom_remap_test();
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] mapped;
        for (int bank = 4; bank < 8; bank++) begin
            for (int j = 0; j < ROM_PER_BANK; j++) begin
                addr     = {3'(bank), 2'(lcg_next()), 17'(lcg_next())};
                addr[16] = j[0];
                mapped   = rom_remap(addr);
                read_expect(addr, mapped[7:0] ^ 8'h5A, 1'b0);
                compare_value("rom_addr", 32'(mapped), 32'(rom_seen));
            end
        end
    endtask

    task automatic error_response_test();
        logic [OFFS_W-1:0] offs;
        logic [DATA_W-1:0] keep;
        logic [ADDR_W-1:0] seen_before;
        offs        = 15'(lcg_next()) & 15'h07FF;
        keep        = ram_model[offs[RAM_AW-1:0]];
        seen_before = rom_seen;
        read_expect(io_addr(REG_RAM, offs), keep, 1'b0);
        // ROM write sharing the low address bits of the RAM byte
        write_expect({3'b101, 2'b00, 6'b000000, offs[10:0]}, ~keep, 1'b1);
        read_expect(io_addr(REG_RAM, offs), keep, 1'b0);
        write_expect(io_addr(6'h2A, offs), ~keep, 1'b1);
        read_expect(io_addr(6'h2A, offs), 8'hFF, 1'b1);
        read_expect(io_addr(REG_RAM, offs), keep, 1'b0);
        // No ROM access since the last ROM read
        compare_value("rom_addr", 32'(seen_before), 32'(rom_seen));
    endtask

    initial begin
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        reset_checks();
        ram_mirror_test();
        vram_lane_test();
        key_chip_test();
        rom_remap_test();
        error_response_test();
        @(negedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a transfer never completed",
                 WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- list.f
rtl/jtshouse_pkg.sv
rtl/jtshouse_apb_port.sv
rtl/jtshouse_bus_decode.sv
rtl/jtshouse_key.sv
rtl/jtshouse_bus_access.sv
rtl/jtshouse_bus.sv
tests/jtshouse_bus_sva.sv
tests/jtshouse_bus_tb.sv

//--- Makefile
# Verilator build and run for the CPU bus model

VERILATOR ?= verilator
TOP       ?= jtshouse_bus_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Finished with no errors

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)

# The log decides pass or fail
run: $(SIM)
	$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
